//--- all.f
hw/mul_arith_pkg.sv
hw/mul_ctrl_pkg.sv
hw/mul_sequencer.sv
hw/csa_row.sv
hw/product_collector.sv
hw/signed_multiplier.sv
bench/product_checker.sv
bench/tb_signed_multiplier.sv

//--- bench/product_checker.sv
`timescale 1ns/1ps

module product_checker (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             valid_in,
	input  logic [mul_arith_pkg::WORD_W-1:0] a,
	input  logic [mul_arith_pkg::WORD_W-1:0] b,
	input  logic [mul_arith_pkg::WORD_W-1:0] product,
	input  logic                             valid_out,
	output int                               error_count
);

	logic [mul_arith_pkg::WORD_W-1:0] exp_prod;
	logic [2:0] busy;   // passes left for the accepted pair.
	logic seen;
	logic accept;
	int errors = 0;

	// a pair is taken only when no passes are pending.
	assign accept = valid_in && (busy == 3'd0);
	assign error_count = errors;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 3'd0;
			seen <= 1'b0;
			exp_prod <= '0;
		end else if (accept) begin
			busy <= 3'd4;
			seen <= 1'b1;
			exp_prod <= a * b;   // low word, same for signed and unsigned.
		end else if (busy != 3'd0) begin
			busy <= busy - 3'd1;
		end
	end

	a_reset_value: assert property (@(posedge clk) disable iff (!arst_n)
		!seen |-> (!valid_out && product == '0))
		else begin
			$display("** Error @ %t: before the first accept valid_out %b product %h",
				$time, $sampled(valid_out), $sampled(product));
			errors++;
		end

	a_busy_low: assert property (@(posedge clk) disable iff (!arst_n)
		(busy != 3'd0) |-> !valid_out)
		else begin
			$display("** Error @ %t: valid_out high with %0d passes left",
				$time, $sampled(busy));
			errors++;
		end

	a_result: assert property (@(posedge clk) disable iff (!arst_n)
		(seen && busy == 3'd0) |-> (valid_out && product == exp_prod))
		else begin
			$display("** Error @ %t: valid_out %b product %h, expected %h",
				$time, $sampled(valid_out), $sampled(product), $sampled(exp_prod));
			errors++;
		end

	// done without a new strobe keeps the result.
	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(seen && busy == 3'd0 && !valid_in) |=> (valid_out && $stable(product)))
		else begin
			$display("** Error @ %t: result did not hold in done, product %h",
				$time, $sampled(product));
			errors++;
		end

endmodule

//--- bench/tb_signed_multiplier.sv
`timescale 1ns/1ps

module tb_signed_multiplier;

	localparam int W = mul_arith_pkg::WORD_W;
	localparam int WAIT_LIMIT = 12;   // cycles allowed for one result.
	localparam int PASS_CYCLES = 4;
	localparam int BACK_OPS = 6;

	logic clk;
	logic arst_n;
	logic valid_in;
	logic [W-1:0] a;
	logic [W-1:0] b;
	logic [W-1:0] product;
	logic valid_out;
	int check_errors;
	int tests_run;
	int tests_failed;
	bit timed_out;

	signed_multiplier dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.valid_in  (valid_in),
		.a         (a),
		.b         (b),
		.product   (product),
		.valid_out (valid_out)
	);

	product_checker u_check (
		.clk         (clk),
		.arst_n      (arst_n),
		.valid_in    (valid_in),
		.a           (a),
		.b           (b),
		.product     (product),
		.valid_out   (valid_out),
		.error_count (check_errors)
	);

	always #20 clk = ~clk;

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [W-1:0] rand_word();
		return {$urandom, $urandom};
	endfunction

	task automatic wait_result(input string name);
		int n;
		n = 0;
		while (!valid_out && !timed_out) begin
			if (n == WAIT_LIMIT) begin
				timed_out = 1'b1;
				$display("%s: valid_out did not rise within %0d cycles", name, WAIT_LIMIT);
			end else begin
				tick();
				n++;
			end
		end
		if (!timed_out)
			tick();   // one edge in done, so the finished result is sampled.
	endtask

	// strobe one pair, optionally stirring the inputs during the passes.
	task automatic run_op(input logic [W-1:0] x, input logic [W-1:0] y, input bit stir);
		a = x;
		b = y;
		valid_in = 1'b1;
		tick();
		if (stir) begin
			repeat (PASS_CYCLES) begin
				valid_in = 1'($urandom);
				a = rand_word();
				b = rand_word();
				tick();
			end
		end
		valid_in = 1'b0;
		wait_result("operation");
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (check_errors != errs_before || timed_out) begin
			tests_failed++;
			$display("%s: fail", name);
		end else begin
			$display("%s: pass", name);
		end
	endtask

	initial begin
		int errs;
		$timeformat(-9, 0, " ns", 10);
		void'($urandom(54022));
		clk = 1'b0;
		arst_n = 1'b0;
		valid_in = 1'b0;
		a = '0;
		b = '0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;

		errs = check_errors;
		repeat (6) begin   // operands move, no strobe.
			a = rand_word();
			b = rand_word();
			tick();
		end
		finish_test("reset_state", errs);

		errs = check_errors;
		run_op('0, rand_word(), 1'b0);
		run_op(rand_word(), '0, 1'b0);
		run_op(64'd1, rand_word(), 1'b0);
		run_op(rand_word(), 64'd1, 1'b0);
		finish_test("zero_and_one", errs);

		errs = check_errors;
		for (int i = 0; i < W; i += 7) begin
			run_op(64'd1 << i, 64'd1 << ($urandom % W), 1'b0);
			run_op(64'd1 << i, 64'd1 << (W - 1 - i), 1'b0);
		end
		finish_test("powers_of_two", errs);

		errs = check_errors;
		run_op('1, '1, 1'b0);
		run_op(64'hffff_ffff_ffff_fffb, 64'd1, 1'b0);   // -5 by 1.
		run_op(64'd1, 64'h8000_0000_0000_0000, 1'b0);
		run_op(64'hffff_ffff_ffff_fffd, 64'hffff_ffff_ffff_fff9, 1'b0);
		finish_test("signed_corners", errs);

		errs = check_errors;
		repeat (8) run_op(rand_word(), rand_word(), 1'b1);
		finish_test("inputs_during_passes", errs);

		errs = check_errors;
		a = rand_word();
		b = rand_word();
		valid_in = 1'b1;
		tick();
		repeat (BACK_OPS * (PASS_CYCLES + 1)) begin
			a = rand_word();
			b = rand_word();
			tick();
		end
		valid_in = 1'b0;
		wait_result("back_to_back");
		finish_test("back_to_back", errs);

		errs = check_errors;
		run_op(rand_word(), rand_word(), 1'b0);
		repeat (8) begin
			a = rand_word();
			b = rand_word();
			tick();
		end
		finish_test("hold_in_done", errs);

		errs = check_errors;
		repeat (40) run_op(rand_word(), rand_word(), 1'($urandom));
		finish_test("random_pairs", errs);

		$display("tests %0d, failed %0d, assertion errors %0d, timeout %0d",
			tests_run, tests_failed, check_errors, timed_out);
		if (tests_failed == 0 && check_errors == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- hw/csa_row.sv
`timescale 1ns/1ps

module csa_row (
	input  mul_arith_pkg::row_bus_t          row_in,
	input  logic [mul_arith_pkg::WORD_W-1:0] mcand,
	input  logic                             mbit,
	input  logic                             correct,
	output mul_arith_pkg::row_bus_t          row_out
);

	logic [mul_arith_pkg::WORD_W-1:0] pp;
	logic [mul_arith_pkg::WORD_W-2:0] in_sum;
	logic [mul_arith_pkg::WORD_W-2:0] in_pp;
	logic [mul_arith_pkg::WORD_W-2:0] in_carry;
	logic [mul_arith_pkg::WORD_W-2:0] fa_sum;
	logic [mul_arith_pkg::WORD_W-2:0] fa_carry;

	assign pp = mcand & {mul_arith_pkg::WORD_W{mbit}};   // partial product.

	// previous sum moves down one place, its inverted msb fills the top.
	assign in_sum = {row_in.msb, row_in.sum[mul_arith_pkg::WORD_W-2:1]};
	assign in_carry = row_in.carry;

	// On the last row of the last pass bit 0 sits at weight 2^63.
	// Flipping it cancels the 2^63 left by row 0's inverted msb,
	// so the low word stays exact for signed operands too.
	assign in_pp = pp[mul_arith_pkg::WORD_W-2:0] ^
		{{(mul_arith_pkg::WORD_W - 2){1'b0}}, correct};

	for (genvar i = 0; i < mul_arith_pkg::WORD_W - 1; i++) begin : g_fa
		assign fa_sum[i] = in_sum[i] ^ in_pp[i] ^ in_carry[i];
		assign fa_carry[i] = (in_sum[i] & in_pp[i]) |
			(in_carry[i] & (in_sum[i] ^ in_pp[i]));
	end

	assign row_out.sum = fa_sum;
	assign row_out.carry = fa_carry;   // weight one above its column.
	assign row_out.msb = ~pp[mul_arith_pkg::WORD_W-1];

endmodule

//--- hw/mul_arith_pkg.sv
package mul_arith_pkg;

	localparam int WORD_W = 64;   // operand and product width.
	localparam int ROWS = 16;     // multiplier bits per pass, one per row.
	localparam int PASSES = 4;

	// carry-save state handed from one row to the next.
	// sum and carry are aligned to the row they leave, so the next row
	// shifts sum down one place and takes carry as it is.
	typedef struct packed {
		logic [WORD_W-2:0] sum;
		logic [WORD_W-2:0] carry;
		logic              msb;   // inverted top partial product bit.
	} row_bus_t;

endpackage

//--- hw/mul_ctrl_pkg.sv
package mul_ctrl_pkg;

	// one state per pass, plus the two resting states.
	typedef enum logic [2:0] {
		st_idle  = 3'd0,
		st_pass0 = 3'd1,
		st_pass1 = 3'd2,
		st_pass2 = 3'd3,
		st_pass3 = 3'd4,
		st_done  = 3'd5
	} mul_state_e;

	// which pass is on the rows this cycle.
	typedef struct packed {
		logic       active;
		logic       first;
		logic       last;
		logic [1:0] index;   // selects the multiplier and product slice.
	} pass_ctrl_t;

endpackage

//--- hw/mul_sequencer.sv
`timescale 1ns/1ps

module mul_sequencer (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             valid_in,
	input  logic [mul_arith_pkg::WORD_W-1:0] a,
	input  logic [mul_arith_pkg::WORD_W-1:0] b,
	output mul_ctrl_pkg::pass_ctrl_t         ctrl,
	output logic [mul_arith_pkg::WORD_W-1:0] mcand,
	output logic [mul_arith_pkg::ROWS-1:0]   mplier_bits,
	output logic [mul_arith_pkg::ROWS-1:0]   correct
);

	mul_ctrl_pkg::mul_state_e state;
	mul_ctrl_pkg::mul_state_e state_nxt;
	logic [mul_arith_pkg::WORD_W-1:0] a_q;
	logic [mul_arith_pkg::WORD_W-1:0] b_q;
	logic accept;

	// a new pair is taken only between operations.
	assign accept = valid_in &&
		(state == mul_ctrl_pkg::st_idle || state == mul_ctrl_pkg::st_done);

	always_comb begin
		state_nxt = state;
		case (state)
			mul_ctrl_pkg::st_idle,
			mul_ctrl_pkg::st_done: begin
				if (valid_in)
					state_nxt = mul_ctrl_pkg::st_pass0;
			end
			mul_ctrl_pkg::st_pass0:
				state_nxt = mul_ctrl_pkg::st_pass1;
			mul_ctrl_pkg::st_pass1:
				state_nxt = mul_ctrl_pkg::st_pass2;
			mul_ctrl_pkg::st_pass2:
				state_nxt = mul_ctrl_pkg::st_pass3;
			mul_ctrl_pkg::st_pass3:
				state_nxt = mul_ctrl_pkg::st_done;
			default:
				state_nxt = mul_ctrl_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= mul_ctrl_pkg::st_idle;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a_q <= a;
			b_q <= b;
		end
	end

	always_comb begin
		ctrl = '0;
		ctrl.active = 1'b1;
		case (state)
			mul_ctrl_pkg::st_pass0:
				ctrl.index = 2'd0;
			mul_ctrl_pkg::st_pass1:
				ctrl.index = 2'd1;
			mul_ctrl_pkg::st_pass2:
				ctrl.index = 2'd2;
			mul_ctrl_pkg::st_pass3:
				ctrl.index = 2'd3;
			default:
				ctrl.active = 1'b0;
		endcase
		ctrl.first = ctrl.active && (ctrl.index == 2'd0);
		ctrl.last = ctrl.active && (ctrl.index == 2'(mul_arith_pkg::PASSES - 1));
	end

	assign mcand = b_q;

	// pass p works on multiplier bits 16p up to 16p+15.
	assign mplier_bits = a_q[ctrl.index * mul_arith_pkg::ROWS +: mul_arith_pkg::ROWS];

	// only row 15 of the last pass gets the correction.
	assign correct = {ctrl.last, {(mul_arith_pkg::ROWS - 1){1'b0}}};

	a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
		state inside {mul_ctrl_pkg::st_idle, mul_ctrl_pkg::st_pass0,
			mul_ctrl_pkg::st_pass1, mul_ctrl_pkg::st_pass2,
			mul_ctrl_pkg::st_pass3, mul_ctrl_pkg::st_done})
		else $error("sequencer state %0d is not a legal encoding", state);

	// each pass lasts one cycle, pass3 steps into done.
	a_pass_step: assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.active |=> (state == $past(state) + 3'd1))
		else $error("sequencer skipped or stalled a pass");

endmodule

//--- hw/product_collector.sv
`timescale 1ns/1ps

module product_collector (
	input  logic                             clk,
	input  logic                             arst_n,
	input  mul_ctrl_pkg::pass_ctrl_t         ctrl,
	input  mul_arith_pkg::row_bus_t          last_row,
	input  logic [mul_arith_pkg::ROWS-1:0]   low_bits,
	output mul_arith_pkg::row_bus_t          fb_bus,
	output logic [mul_arith_pkg::WORD_W-1:0] product,
	output logic                             valid_out
);

	mul_arith_pkg::row_bus_t last_q;
	logic done_q;

	// row 15 state carried into the next pass.
	always_ff @(posedge clk) begin
		if (ctrl.active)
			last_q <= last_row;
	end

	always_comb begin
		fb_bus = last_q;
		if (ctrl.first)
			fb_bus = '0;   // empty accumulator.
	end

	// slice p holds product bits 16p up to 16p+15.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			product <= '0;
		else if (ctrl.active)
			product[ctrl.index * mul_arith_pkg::ROWS +: mul_arith_pkg::ROWS] <= low_bits;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done_q <= 1'b0;
		end else if (ctrl.last) begin
			done_q <= 1'b1;
		end else if (ctrl.first) begin
			done_q <= 1'b0;
		end
	end

	// a fresh accept retires the old result at once.
	assign valid_out = done_q && !ctrl.first;

	a_no_valid_in_pass: assert property (@(posedge clk) disable iff (!arst_n)
		!(valid_out && ctrl.active))
		else $error("valid_out high during pass %0d", ctrl.index);

endmodule

//--- hw/signed_multiplier.sv
`timescale 1ns/1ps

module signed_multiplier (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             valid_in,
	input  logic [mul_arith_pkg::WORD_W-1:0] a,
	input  logic [mul_arith_pkg::WORD_W-1:0] b,
	output logic [mul_arith_pkg::WORD_W-1:0] product,
	output logic                             valid_out
);

	mul_ctrl_pkg::pass_ctrl_t ctrl;
	logic [mul_arith_pkg::WORD_W-1:0] mcand;
	logic [mul_arith_pkg::ROWS-1:0] mplier_bits;
	logic [mul_arith_pkg::ROWS-1:0] correct;
	logic [mul_arith_pkg::ROWS-1:0] low_bits;
	mul_arith_pkg::row_bus_t row_bus [mul_arith_pkg::ROWS + 1];   // [0] is feedback.

	mul_sequencer u_seq (
		.clk         (clk),
		.arst_n      (arst_n),
		.valid_in    (valid_in),
		.a           (a),
		.b           (b),
		.ctrl        (ctrl),
		.mcand       (mcand),
		.mplier_bits (mplier_bits),
		.correct     (correct)
	);

	for (genvar i = 0; i < mul_arith_pkg::ROWS; i++) begin : g_row
		csa_row u_row (
			.row_in  (row_bus[i]),
			.mcand   (mcand),
			.mbit    (mplier_bits[i]),
			.correct (correct[i]),
			.row_out (row_bus[i+1])
		);

		assign low_bits[i] = row_bus[i+1].sum[0];   // settled product bit.
	end

	product_collector u_coll (
		.clk       (clk),
		.arst_n    (arst_n),
		.ctrl      (ctrl),
		.last_row  (row_bus[mul_arith_pkg::ROWS]),
		.low_bits  (low_bits),
		.fb_bus    (row_bus[0]),
		.product   (product),
		.valid_out (valid_out)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log.
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
	-f all.f \
	--top-module tb_signed_multiplier \
	--Mdir "$build_dir" \
	-o sim_tb

"./$build_dir/sim_tb" | tee "$log"

if grep -q "^TEST PASSED$" "$log"; then
	exit 0
else
	echo "simulation did not pass, see $log"
	exit 1
fi
